// File: list.f
+incdir+tb
rtl/stream_pkg.sv
rtl/stream_arbiter.sv
rtl/stream_demux_unit.sv
rtl/stream_switch.sv
tb/stream_switch_tb.sv

// File: rtl/stream_arbiter.sv
////////////////////////////////////////////////////////////
// Packet-locked round-robin arbiter.
// Merges the ingress streams onto one stream and writes
// the index of the winning ingress into tid.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stream_arbiter (
    input  logic                                          aclk,
    input  logic                                          areset_n,
    input  logic [stream_pkg::INPUTS-1:0]                 in_valid,
    input  stream_pkg::stream_beat_t [stream_pkg::INPUTS-1:0] in_beat,
    output logic [stream_pkg::INPUTS-1:0]                 in_ready,
    output logic                                          out_valid,
    output stream_pkg::stream_beat_t                      out_beat,
    input  logic                                          out_ready
);
    import stream_pkg::*;

    // While a packet is open, grant_q is the granted ingress.
    // Between packets it is the first ingress the search looks at.
    logic [ID_WIDTH-1:0] grant_q;
    logic                pkt_open_q;

    logic [ID_WIDTH-1:0] pick;
    logic                pick_found;
    logic [ID_WIDTH-1:0] sel;
    logic                req;
    logic [ID_WIDTH-1:0] next_ptr;
    logic                accept;

    // Round-robin search over the requests, starting at grant_q.
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick = grant_q;
        for (int i = 0; i < INPUTS; i++) begin
            idx = (int'(grant_q) + i) % INPUTS;
            if (!pick_found && in_valid[idx]) begin
                pick_found = 1'b1;
                pick = ID_WIDTH'(idx);
            end
        end
    end

    // An open packet keeps its source until tlast is accepted.
    always_comb begin
        if (pkt_open_q) begin
            sel = grant_q;
            req = in_valid[grant_q];
        end
        else begin
            sel = pick;
            req = pick_found;
        end
    end

    // Data path is combinational, so a granted beat leaves this cycle.
    always_comb begin
        out_beat = in_beat[sel];
        out_beat.tid = sel;
    end

    always_comb out_valid = req;

    // Only the granted ingress sees ready.
    always_comb begin
        for (int i = 0; i < INPUTS; i++) begin
            in_ready[i] = out_ready && req && (sel == ID_WIDTH'(i));
        end
    end

    always_comb accept = req && out_ready;

    // Search starts one past the winner once its packet closes.
    always_comb next_ptr = ID_WIDTH'((int'(sel) + 1) % INPUTS);

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            grant_q <= '0;
            pkt_open_q <= 1'b0;
        end
        else if (accept) begin
            if (out_beat.tlast) begin
                grant_q <= next_ptr;
                pkt_open_q <= 1'b0;
            end
            else begin
                // Lock onto this source for the rest of the packet.
                grant_q <= sel;
                pkt_open_q <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/stream_demux_unit.sv
////////////////////////////////////////////////////////////
// Registered demux stage.
// Routes tdest BASE to BASE+OUTPUTS-1 to its own outputs and
// passes every other beat on to the next stage.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stream_demux_unit #(
    parameter int BASE    = 0,
    parameter int OUTPUTS = 2
) (
    input  logic                                  aclk,
    input  logic                                  areset_n,
    input  logic                                  in_valid,
    input  stream_pkg::stream_beat_t              in_beat,
    output logic                                  in_ready,
    output logic [OUTPUTS-1:0]                    out_valid,
    output stream_pkg::stream_beat_t [OUTPUTS-1:0] out_beat,
    input  logic [OUTPUTS-1:0]                    out_ready,
    output logic                                  pass_valid,
    output stream_pkg::stream_beat_t              pass_beat,
    input  logic                                  pass_ready
);
    import stream_pkg::*;

    // Index OUTPUTS is the pass-on port.
    localparam int SELECT = OUTPUTS + 1;

    logic [SELECT-1:0] select;
    logic [SELECT-1:0] ready;

    // One-hot selects from tdest.
    // Pass-on is taken when no local port matches.
    always_comb begin
        select = '0;
        for (int i = 0; i < OUTPUTS; i++) begin
            select[i] = (in_beat.tdest == DEST_WIDTH'(BASE + i));
        end
        select[OUTPUTS] = ~|select[OUTPUTS-1:0];
    end

    always_comb begin
        ready[OUTPUTS-1:0] = out_ready;
        ready[OUTPUTS] = pass_ready;
    end

    // A stalled output only blocks the input while it is the one selected.
    always_comb in_ready = !in_valid || |(ready & select);

    // Pass-on register.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            pass_valid <= 1'b0;
        end
        else if (pass_ready) begin
            pass_valid <= in_valid && select[OUTPUTS];
        end
    end

    always_ff @(posedge aclk) begin
        if (pass_ready) begin
            pass_beat <= in_beat;
        end
    end

    // One register per local output, each enabled by its own ready.
    for (genvar k = 0; k < OUTPUTS; k++) begin : g_outputs
        always_ff @(posedge aclk or negedge areset_n) begin
            if (!areset_n) begin
                out_valid[k] <= 1'b0;
            end
            else if (out_ready[k]) begin
                out_valid[k] <= in_valid && select[k];
            end
        end

        // Payload follows the input whenever the port can take it.
        always_ff @(posedge aclk) begin
            if (out_ready[k]) begin
                out_beat[k] <= in_beat;
            end
        end
    end

endmodule

// File: rtl/stream_pkg.sv
////////////////////////////////////////////////////////////
// Stream switch package.
// Port counts, field widths and the beat type shared by
// the arbiter, the demux stages and the switch top.
////////////////////////////////////////////////////////////
package stream_pkg;

    // Bytes carried in tdata.
    localparam int DATA_BYTES = 4;

    // Width of the routing field.
    localparam int DEST_WIDTH = 3;

    // Number of ingress streams.
    localparam int INPUTS = 4;

    // Number of destination ports, default port not counted.
    localparam int DEST_PORTS = 4;

    // Source tag width, wide enough to name one ingress.
    localparam int ID_WIDTH = 2;

    // One AXI4-Stream beat.
    // Valid and ready travel beside it as separate signals.
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] tdata;
        logic [DATA_BYTES-1:0]   tkeep;
        logic                    tlast;
        logic [DEST_WIDTH-1:0]   tdest;
        logic [ID_WIDTH-1:0]     tid;
        logic                    tuser;
    } stream_beat_t;

endpackage

// File: rtl/stream_switch.sv
////////////////////////////////////////////////////////////
// AXI4-Stream switch top.
// Round-robin arbiter followed by two chained demux stages;
// unmatched tdest values leave through the default port.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stream_switch (
    input  logic                                              aclk,
    input  logic                                              areset_n,
    input  logic [stream_pkg::INPUTS-1:0]                     in_valid,
    output logic [stream_pkg::INPUTS-1:0]                     in_ready,
    input  stream_pkg::stream_beat_t [stream_pkg::INPUTS-1:0] in_beat,
    output logic [stream_pkg::DEST_PORTS-1:0]                 out_valid,
    input  logic [stream_pkg::DEST_PORTS-1:0]                 out_ready,
    output stream_pkg::stream_beat_t [stream_pkg::DEST_PORTS-1:0] out_beat,
    output logic                                              dflt_valid,
    input  logic                                              dflt_ready,
    output stream_pkg::stream_beat_t                          dflt_beat
);
    import stream_pkg::*;

    // Merged stream from the arbiter into stage 0.
    logic         merged_valid;
    logic         merged_ready;
    stream_beat_t merged_beat;

    // Beats stage 0 does not serve, into stage 1.
    logic         pass_valid;
    logic         pass_ready;
    stream_beat_t pass_beat;

    stream_arbiter u_arbiter (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (merged_valid),
        .out_beat  (merged_beat),
        .out_ready (merged_ready)
    );

    // Stage 0 serves tdest 0 and 1.
    stream_demux_unit #(
        .BASE    (0),
        .OUTPUTS (DEST_PORTS / 2)
    ) u_demux_0 (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .in_valid   (merged_valid),
        .in_beat    (merged_beat),
        .in_ready   (merged_ready),
        .out_valid  (out_valid[DEST_PORTS/2-1:0]),
        .out_beat   (out_beat[DEST_PORTS/2-1:0]),
        .out_ready  (out_ready[DEST_PORTS/2-1:0]),
        .pass_valid (pass_valid),
        .pass_beat  (pass_beat),
        .pass_ready (pass_ready)
    );

    // Stage 1 serves tdest 2 and 3, its pass-on is the default port.
    stream_demux_unit #(
        .BASE    (DEST_PORTS / 2),
        .OUTPUTS (DEST_PORTS / 2)
    ) u_demux_1 (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .in_valid   (pass_valid),
        .in_beat    (pass_beat),
        .in_ready   (pass_ready),
        .out_valid  (out_valid[DEST_PORTS-1:DEST_PORTS/2]),
        .out_beat   (out_beat[DEST_PORTS-1:DEST_PORTS/2]),
        .out_ready  (out_ready[DEST_PORTS-1:DEST_PORTS/2]),
        .pass_valid (dflt_valid),
        .pass_beat  (dflt_beat),
        .pass_ready (dflt_ready)
    );

endmodule

// File: run.sh
#!/bin/sh
# Builds the stream switch testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f list.f \
    --top-module stream_switch_tb \
    -o stream_switch_sim

# The simulation log decides the result.
./obj_dir/stream_switch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: tb/stream_switch_tb_ref.svh
////////////////////////////////////////////////////////////
// Stream switch testbench helpers.
// Random source, routing reference and compare tasks.
////////////////////////////////////////////////////////////
`ifndef STREAM_SWITCH_TB_REF_SVH
`define STREAM_SWITCH_TB_REF_SVH

logic [31:0] lfsr_state = 32'h1326;

// Galois LFSR, one step per random bit.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

// Ports 0 to 3 take their own tdest, the default port takes the rest.
function automatic int route_port(input logic [DEST_WIDTH-1:0] dest);
    if (int'(dest) < DEST_PORTS) begin
        return int'(dest);
    end
    return DEST_PORTS;
endfunction

// Expected beats, indexed by port times INPUTS plus source.
stream_beat_t exp_q[(DEST_PORTS+1)*INPUTS][$];
int           exp_cyc[(DEST_PORTS+1)*INPUTS][$];

task automatic check_beat(input string name, input stream_beat_t exp, input stream_beat_t act);
    if (act !== exp) begin
        stop_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
endtask

// Default port valid in the top bit, destination ports below it.
task automatic check_valid(input string name, input logic [DEST_PORTS:0] exp,
                           input logic [DEST_PORTS:0] act);
    if (act !== exp) begin
        stop_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
endtask

task automatic check_port(input string name, input int exp, input int act);
    if (act != exp) begin
        stop_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
    end
endtask

`endif

// File: tb/stream_switch_tb.sv
////////////////////////////////////////////////////////////
// Stream switch testbench.
// Drives the ingresses, throttles the outputs and checks
// every output beat against the routing reference.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stream_switch_tb;
    import stream_pkg::*;

    localparam int TIMEOUT = 20000;

    logic                                aclk = 1'b0;
    logic                                areset_n = 1'b0;
    logic [INPUTS-1:0]                   in_valid = '0;
    logic [INPUTS-1:0]                   in_ready;
    stream_beat_t [INPUTS-1:0]           in_beat = '0;
    logic [DEST_PORTS-1:0]               out_valid;
    logic [DEST_PORTS-1:0]               out_ready = '1;
    stream_beat_t [DEST_PORTS-1:0]       out_beat;
    logic                                dflt_valid;
    logic                                dflt_ready = 1'b1;
    stream_beat_t                        dflt_beat;

    string test_name = "reset";
    int    cycle_count = 0;
    logic  throttle = 1'b0;
    logic  check_lat = 1'b0;
    logic  rr_check = 1'b0;
    logic  rr_seen = 1'b0;
    int    rr_last = 0;
    logic  open_pkt[DEST_PORTS+1];
    int    open_tid[DEST_PORTS+1];

    // Beats waiting to be offered at each ingress.
    stream_beat_t pend_q[INPUTS][$];

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    `include "stream_switch_tb_ref.svh"

    stream_switch u_stream_switch (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .dflt_valid (dflt_valid),
        .dflt_ready (dflt_ready),
        .dflt_beat  (dflt_beat)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    function automatic stream_beat_t make_beat(input int dest, input logic last);
        stream_beat_t b;
        b.tdata = rand_bits(32);
        b.tkeep = DATA_BYTES'(rand_bits(DATA_BYTES));
        b.tlast = last;
        b.tdest = DEST_WIDTH'(dest);
        // Arbiter overwrites tid, so junk goes in.
        b.tid = ID_WIDTH'(rand_bits(ID_WIDTH));
        b.tuser = rand_bits(1) != 0;
        return b;
    endfunction

    task automatic queue_packet(input int src, input int len, input int dest);
        for (int k = 0; k < len; k++) begin
            pend_q[src].push_back(make_beat(dest, k == len - 1));
        end
    endtask

    // Ingress driver and expected-beat recording.
    always @(posedge aclk) begin
        stream_beat_t b;
        for (int s = 0; s < INPUTS; s++) begin
            if (in_valid[s] && in_ready[s]) begin
                b = pend_q[s].pop_front();
                b.tid = ID_WIDTH'(s);
                exp_q[route_port(b.tdest)*INPUTS+s].push_back(b);
                exp_cyc[route_port(b.tdest)*INPUTS+s].push_back(cycle_count);
            end
            if (pend_q[s].size() > 0) begin
                in_valid[s] <= 1'b1;
                in_beat[s] <= pend_q[s][0];
            end
            else begin
                in_valid[s] <= 1'b0;
            end
        end
        if (throttle) begin
            out_ready <= DEST_PORTS'(rand_bits(DEST_PORTS));
            dflt_ready <= rand_bits(1) != 0;
        end
        else begin
            out_ready <= '1;
            dflt_ready <= 1'b1;
        end
    end

    // Output monitor.
    always @(posedge aclk) begin
        stream_beat_t act;
        stream_beat_t exp;
        int           q;
        int           acc_cyc;
        logic         hit;
        if (areset_n) begin
            for (int p = 0; p <= DEST_PORTS; p++) begin
                if (p < DEST_PORTS) begin
                    hit = out_valid[p] && out_ready[p];
                    act = out_beat[p];
                end
                else begin
                    hit = dflt_valid && dflt_ready;
                    act = dflt_beat;
                end
                if (hit) begin
                    q = p * INPUTS + int'(act.tid);
                    if (exp_q[q].size() == 0) begin
                        stop_run($sformatf("%s: unexpected beat on port %0d from source %0d",
                                           test_name, p, act.tid));
                    end
                    exp = exp_q[q].pop_front();
                    acc_cyc = exp_cyc[q].pop_front();
                    check_beat(test_name, exp, act);
                    if (check_lat) begin
                        check_port({test_name, " latency"}, (p < DEST_PORTS / 2) ? 1 : 2,
                                   cycle_count - acc_cyc);
                    end
                    // No other source may cut into an open packet.
                    if (open_pkt[p]) begin
                        check_port({test_name, " packet tid"}, open_tid[p], int'(act.tid));
                    end
                    open_pkt[p] = !act.tlast;
                    open_tid[p] = int'(act.tid);
                    if (rr_check && p == 0) begin
                        if (rr_seen) begin
                            check_port("round_robin", (rr_last + 1) % INPUTS, int'(act.tid));
                        end
                        rr_seen = 1'b1;
                        rr_last = int'(act.tid);
                    end
                end
            end
        end
    end

    function automatic logic all_idle();
        for (int s = 0; s < INPUTS; s++) begin
            if (pend_q[s].size() > 0) return 1'b0;
        end
        for (int q = 0; q < (DEST_PORTS + 1) * INPUTS; q++) begin
            if (exp_q[q].size() > 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_idle();
        int t;
        t = 0;
        while (!all_idle()) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) begin
                stop_run({test_name, ": timeout waiting for the expected beats"});
            end
        end
    endtask

    initial begin
        for (int p = 0; p <= DEST_PORTS; p++) begin
            open_pkt[p] = 1'b0;
            open_tid[p] = 0;
        end
        // Valids stay low through reset and just after it.
        for (int c = 0; c < 8; c++) begin
            @(posedge aclk);
            // Registers are unknown before the first reset edge.
            if (c > 0) begin
                check_valid("reset", '0, {dflt_valid, out_valid});
            end
            if (c == 3) areset_n <= 1'b1;
        end

        test_name = "routing";
        check_lat = 1'b1;
        for (int d = 0; d < 8; d++) begin
            queue_packet(d % INPUTS, 1, d);
        end
        wait_idle();
        check_lat = 1'b0;

        test_name = "integrity";
        for (int s = 0; s < INPUTS; s++) begin
            for (int n = 0; n < 6; n++) begin
                queue_packet(s, 1 + int'(rand_bits(2)), int'(rand_bits(DEST_WIDTH)));
            end
        end
        wait_idle();

        test_name = "round_robin";
        rr_check = 1'b1;
        for (int s = 0; s < INPUTS; s++) begin
            for (int n = 0; n < 8; n++) begin
                queue_packet(s, 1, 0);
            end
        end
        wait_idle();
        rr_check = 1'b0;

        test_name = "backpressure";
        throttle = 1'b1;
        for (int s = 0; s < INPUTS; s++) begin
            for (int n = 0; n < 40; n++) begin
                queue_packet(s, 1 + int'(rand_bits(2)), int'(rand_bits(DEST_WIDTH)));
            end
        end
        wait_idle();
        throttle = 1'b0;

        $display("RESULT: PASS");
        $finish;
    end

endmodule
